/* island_pkg.sv */
/*
 Widths, address map and port counts shared by the island RTL and testbench.
 Windows are base inclusive, end exclusive.
*/

package island_pkg;

   localparam int unsigned ADDR_W = 32;
   localparam int unsigned DATA_W = 32;

   // Requester 0 is rot, 1 is cls
   localparam int unsigned NUM_REQ = 2;
   // Target 0 is soc (host), 1 is clus
   localparam int unsigned NUM_TGT = 2;

   localparam int unsigned SYNC_STAGES = 3;

   ////////////////////////////////////////////////////////////
   // Address map
   ////////////////////////////////////////////////////////////

   localparam logic [ADDR_W-1:0] HOST_BASE = 32'h0001_0000;
   localparam logic [ADDR_W-1:0] HOST_END  = 32'hA000_0000;
   localparam logic [ADDR_W-1:0] CLS_BASE  = 32'hA100_0000;
   localparam logic [ADDR_W-1:0] CLS_END   = 32'hB000_0000;

   // Values of the first two match the target index
   typedef enum logic [1:0] {
      TGT_SOC  = 2'd0,
      TGT_CLUS = 2'd1,
      TGT_MISS = 2'd2
   } tgt_sel_t;

endpackage

/* island_bus_if.sv */
/*
 One requester link into the crossbar. req and the payload stay stable
 until gnt; one transaction outstanding per link.
*/

`timescale 1ns/100ps

interface island_bus_if;

   import island_pkg::*;

   logic              req;
   logic              we;
   logic [ADDR_W-1:0] addr;
   logic [DATA_W-1:0] wdata;
   logic              gnt;
   logic              rsp;
   logic [DATA_W-1:0] rdata;
   logic              err;

   modport requester (
      output req,
      output we,
      output addr,
      output wdata,
      input  gnt,
      input  rsp,
      input  rdata,
      input  err
   );

   modport xbar (
      input  req,
      input  we,
      input  addr,
      input  wdata,
      output gnt,
      output rsp,
      output rdata,
      output err
   );

endinterface

/* island_sync.sv */
/*
 Flop chain synchronizer, SYNC_STAGES deep per bit. Bits are independent,
 so a multi-bit value may skew by a cycle across bits.
*/

`timescale 1ns/100ps

module island_sync #(
   parameter int unsigned WIDTH = 1
) (
   input  logic             clk_i,
   input  logic             rst_i,
   input  logic [WIDTH-1:0] async_i,
   output logic [WIDTH-1:0] sync_o
);

   import island_pkg::*;

   logic [WIDTH-1:0] stage_q [SYNC_STAGES];

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         for (int i = 0; i < SYNC_STAGES; i++) begin
            stage_q[i] <= '0;
         end
      end else begin
         stage_q[0] <= async_i;
         for (int i = 1; i < SYNC_STAGES; i++) begin
            stage_q[i] <= stage_q[i-1];
         end
      end
   end

   assign sync_o = stage_q[SYNC_STAGES-1];

endmodule

/* island_tgt_arbiter.sv */
/*
 Two-way round-robin arbiter for a single target, one request in flight.
 owner_o shows the held owner while busy and the next winner while idle.
*/

`timescale 1ns/100ps

module island_tgt_arbiter (
   input  logic                        clk_i,
   input  logic                        rst_i,
   input  logic [island_pkg::NUM_REQ-1:0] want_i,
   input  logic                        tgt_rsp_i,
   output logic [island_pkg::NUM_REQ-1:0] gnt_o,
   output logic                        owner_o,
   output logic                        issue_o
);

   import island_pkg::*;

   logic               busy_q;
   logic               owner_q;
   logic               ptr_q;
   logic               winner;
   logic               arb_go;
   logic [NUM_REQ-1:0] gnt_q;
   logic               issue_q;

   // Pointer holds the preferred requester
   assign winner = want_i[ptr_q] ? ptr_q : ~ptr_q;
   assign arb_go = !busy_q && (|want_i);

   ////////////////////////////////////////////////////////////
   // Grant and outstanding tracking
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy_q  <= 1'b0;
         owner_q <= 1'b0;
         ptr_q   <= 1'b0;
         gnt_q   <= '0;
         issue_q <= 1'b0;
      end else begin
         gnt_q   <= '0;
         issue_q <= arb_go;
         if (arb_go) begin
            busy_q        <= 1'b1;
            owner_q       <= winner;
            ptr_q         <= ~winner;
            gnt_q[winner] <= 1'b1;
         end else if (tgt_rsp_i) begin
            busy_q <= 1'b0;
         end
      end
   end

   assign gnt_o   = gnt_q;
   assign issue_o = issue_q;
   assign owner_o = busy_q ? owner_q : winner;

endmodule

/* island_xbar.sv */
/*
 2x2 request crossbar with a per-target round-robin arbiter.
 Addresses outside both windows get an error response and reach no target.
*/

`timescale 1ns/100ps

module island_xbar (
   input  logic                          clk_i,
   input  logic                          rst_i,
   island_bus_if.xbar                    rot,
   island_bus_if.xbar                    cls,
   // Host target
   output logic                          soc_req_o,
   output logic                          soc_we_o,
   output logic [island_pkg::ADDR_W-1:0] soc_addr_o,
   output logic [island_pkg::DATA_W-1:0] soc_wdata_o,
   input  logic                          soc_rsp_i,
   input  logic [island_pkg::DATA_W-1:0] soc_rdata_i,
   input  logic                          soc_err_i,
   // Cluster target
   output logic                          clus_req_o,
   output logic                          clus_we_o,
   output logic [island_pkg::ADDR_W-1:0] clus_addr_o,
   output logic [island_pkg::DATA_W-1:0] clus_wdata_o,
   input  logic                          clus_rsp_i,
   input  logic [island_pkg::DATA_W-1:0] clus_rdata_i,
   input  logic                          clus_err_i
);

   import island_pkg::*;

   function automatic tgt_sel_t decode(input logic [ADDR_W-1:0] a);
      if (a >= HOST_BASE && a < HOST_END) begin
         return TGT_SOC;
      end
      if (a >= CLS_BASE && a < CLS_END) begin
         return TGT_CLUS;
      end
      return TGT_MISS;
   endfunction

   // Requester side, indexed by requester
   logic [NUM_REQ-1:0] req;
   logic [NUM_REQ-1:0] we;
   logic [ADDR_W-1:0]  addr  [NUM_REQ];
   logic [DATA_W-1:0]  wdata [NUM_REQ];
   tgt_sel_t           sel   [NUM_REQ];
   logic [NUM_REQ-1:0] granted;
   logic [NUM_REQ-1:0] gnt;
   logic [NUM_REQ-1:0] rsp;
   logic [DATA_W-1:0]  rdata [NUM_REQ];
   logic [NUM_REQ-1:0] err;

   // Target side, indexed by target
   logic [NUM_TGT-1:0] t_req;
   logic [NUM_TGT-1:0] t_we;
   logic [ADDR_W-1:0]  t_addr  [NUM_TGT];
   logic [DATA_W-1:0]  t_wdata [NUM_TGT];
   logic [NUM_TGT-1:0] t_rsp;
   logic [DATA_W-1:0]  t_rdata [NUM_TGT];
   logic [NUM_TGT-1:0] t_err;
   logic [NUM_TGT-1:0] tgt_owner;
   logic [NUM_REQ-1:0] arb_gnt [NUM_TGT];

   assign req[0]   = rot.req;
   assign we[0]    = rot.we;
   assign addr[0]  = rot.addr;
   assign wdata[0] = rot.wdata;
   assign req[1]   = cls.req;
   assign we[1]    = cls.we;
   assign addr[1]  = cls.addr;
   assign wdata[1] = cls.wdata;

   assign rot.gnt   = gnt[0];
   assign rot.rsp   = rsp[0];
   assign rot.rdata = rdata[0];
   assign rot.err   = err[0];
   assign cls.gnt   = gnt[1];
   assign cls.rsp   = rsp[1];
   assign cls.rdata = rdata[1];
   assign cls.err   = err[1];

   ////////////////////////////////////////////////////////////
   // Per target: arbitration and request port
   ////////////////////////////////////////////////////////////

   for (genvar t = 0; t < NUM_TGT; t++) begin : g_tgt
      logic [NUM_REQ-1:0] want;
      logic               we_q;
      logic [ADDR_W-1:0]  addr_q;
      logic [DATA_W-1:0]  wdata_q;

      for (genvar r = 0; r < NUM_REQ; r++) begin : g_want
         assign want[r] = req[r] && !granted[r] && (sel[r] == tgt_sel_t'(t));
      end

      island_tgt_arbiter i_arb (
         .clk_i     ( clk_i        ),
         .rst_i     ( rst_i        ),
         .want_i    ( want         ),
         .tgt_rsp_i ( t_rsp[t]     ),
         .gnt_o     ( arb_gnt[t]   ),
         .owner_o   ( tgt_owner[t] ),
         .issue_o   ( t_req[t]     )
      );

      // Sampled on the arbitration edge, valid with the req pulse
      always_ff @(posedge clk_i) begin
         we_q    <= we[tgt_owner[t]];
         addr_q  <= addr[tgt_owner[t]];
         wdata_q <= wdata[tgt_owner[t]];
      end

      assign t_we[t]    = we_q;
      assign t_addr[t]  = addr_q;
      assign t_wdata[t] = wdata_q;
   end

   ////////////////////////////////////////////////////////////
   // Per requester: decode, miss path and response return
   ////////////////////////////////////////////////////////////

   for (genvar r = 0; r < NUM_REQ; r++) begin : g_req
      logic              miss_gnt_q;
      logic              pend_q;
      logic              rsp_q;
      logic              err_q;
      logic [DATA_W-1:0] rdata_q;
      logic              arb_any;
      logic              hit;
      logic              hit_err;
      logic [DATA_W-1:0] hit_rdata;

      assign sel[r] = decode(addr[r]);

      always_comb begin
         arb_any   = 1'b0;
         hit       = 1'b0;
         hit_err   = 1'b0;
         hit_rdata = '0;
         for (int t = 0; t < NUM_TGT; t++) begin
            arb_any = arb_any | arb_gnt[t][r];
            if (t_rsp[t] && tgt_owner[t] == 1'(r)) begin
               hit       = 1'b1;
               hit_err   = t_err[t];
               hit_rdata = t_rdata[t];
            end
         end
      end

      assign gnt[r]     = arb_any | miss_gnt_q;
      assign granted[r] = pend_q | gnt[r];

      always_ff @(posedge clk_i) begin
         if (rst_i) begin
            miss_gnt_q <= 1'b0;
            pend_q     <= 1'b0;
            rsp_q      <= 1'b0;
         end else begin
            miss_gnt_q <= req[r] && !granted[r] && (sel[r] == TGT_MISS);
            rsp_q      <= miss_gnt_q | hit;
            if (gnt[r]) begin
               pend_q <= 1'b1;
            end else if (rsp_q) begin
               pend_q <= 1'b0;
            end
         end
      end

      always_ff @(posedge clk_i) begin
         if (miss_gnt_q) begin
            rdata_q <= '0;
            err_q   <= 1'b1;
         end else if (hit) begin
            rdata_q <= hit_rdata;
            err_q   <= hit_err;
         end
      end

      assign rsp[r]   = rsp_q;
      assign rdata[r] = rdata_q;
      assign err[r]   = err_q;
   end

   // Plain target ports
   assign soc_req_o    = t_req[0];
   assign soc_we_o     = t_we[0];
   assign soc_addr_o   = t_addr[0];
   assign soc_wdata_o  = t_wdata[0];
   assign t_rsp[0]     = soc_rsp_i;
   assign t_rdata[0]   = soc_rdata_i;
   assign t_err[0]     = soc_err_i;

   assign clus_req_o   = t_req[1];
   assign clus_we_o    = t_we[1];
   assign clus_addr_o  = t_addr[1];
   assign clus_wdata_o = t_wdata[1];
   assign t_rsp[1]     = clus_rsp_i;
   assign t_rdata[1]   = clus_rdata_i;
   assign t_err[1]     = clus_err_i;

endmodule

/* security_island.sv */
/*
 Security island fabric, single clock. Requesters follow the req/gnt/rsp
 rule; each target must answer every req pulse with exactly one rsp.
*/

`timescale 1ns/100ps

module security_island (
   input  logic                          clk_i,
   input  logic                          rst_i,
   input  logic                          fetch_en_i,
   input  logic                          irq_i,
   output logic                          fetch_en_o,
   output logic                          irq_o,
   // Root-of-trust data port
   input  logic                          rot_req_i,
   input  logic                          rot_we_i,
   input  logic [island_pkg::ADDR_W-1:0] rot_addr_i,
   input  logic [island_pkg::DATA_W-1:0] rot_wdata_i,
   output logic                          rot_gnt_o,
   output logic                          rot_rsp_o,
   output logic [island_pkg::DATA_W-1:0] rot_rdata_o,
   output logic                          rot_err_o,
   // Cluster-to-SoC port
   input  logic                          cls_req_i,
   input  logic                          cls_we_i,
   input  logic [island_pkg::ADDR_W-1:0] cls_addr_i,
   input  logic [island_pkg::DATA_W-1:0] cls_wdata_i,
   output logic                          cls_gnt_o,
   output logic                          cls_rsp_o,
   output logic [island_pkg::DATA_W-1:0] cls_rdata_o,
   output logic                          cls_err_o,
   // Host target
   output logic                          soc_req_o,
   output logic                          soc_we_o,
   output logic [island_pkg::ADDR_W-1:0] soc_addr_o,
   output logic [island_pkg::DATA_W-1:0] soc_wdata_o,
   input  logic                          soc_rsp_i,
   input  logic [island_pkg::DATA_W-1:0] soc_rdata_i,
   input  logic                          soc_err_i,
   // Cluster target
   output logic                          clus_req_o,
   output logic                          clus_we_o,
   output logic [island_pkg::ADDR_W-1:0] clus_addr_o,
   output logic [island_pkg::DATA_W-1:0] clus_wdata_o,
   input  logic                          clus_rsp_i,
   input  logic [island_pkg::DATA_W-1:0] clus_rdata_i,
   input  logic                          clus_err_i
);

   island_bus_if rot_bus ();
   island_bus_if cls_bus ();

   assign rot_bus.req   = rot_req_i;
   assign rot_bus.we    = rot_we_i;
   assign rot_bus.addr  = rot_addr_i;
   assign rot_bus.wdata = rot_wdata_i;
   assign rot_gnt_o     = rot_bus.gnt;
   assign rot_rsp_o     = rot_bus.rsp;
   assign rot_rdata_o   = rot_bus.rdata;
   assign rot_err_o     = rot_bus.err;

   assign cls_bus.req   = cls_req_i;
   assign cls_bus.we    = cls_we_i;
   assign cls_bus.addr  = cls_addr_i;
   assign cls_bus.wdata = cls_wdata_i;
   assign cls_gnt_o     = cls_bus.gnt;
   assign cls_rsp_o     = cls_bus.rsp;
   assign cls_rdata_o   = cls_bus.rdata;
   assign cls_err_o     = cls_bus.err;

   ////////////////////////////////////////////////////////////
   // Input sync
   ////////////////////////////////////////////////////////////

   island_sync #(
      .WIDTH ( 2 )
   ) i_sync (
      .clk_i   ( clk_i                    ),
      .rst_i   ( rst_i                    ),
      .async_i ( {irq_i, fetch_en_i}      ),
      .sync_o  ( {irq_o, fetch_en_o}      )
   );

   ////////////////////////////////////////////////////////////
   // Crossbar
   ////////////////////////////////////////////////////////////

   island_xbar i_xbar (
      .clk_i        ( clk_i        ),
      .rst_i        ( rst_i        ),
      .rot          ( rot_bus      ),
      .cls          ( cls_bus      ),
      .soc_req_o    ( soc_req_o    ),
      .soc_we_o     ( soc_we_o     ),
      .soc_addr_o   ( soc_addr_o   ),
      .soc_wdata_o  ( soc_wdata_o  ),
      .soc_rsp_i    ( soc_rsp_i    ),
      .soc_rdata_i  ( soc_rdata_i  ),
      .soc_err_i    ( soc_err_i    ),
      .clus_req_o   ( clus_req_o   ),
      .clus_we_o    ( clus_we_o    ),
      .clus_addr_o  ( clus_addr_o  ),
      .clus_wdata_o ( clus_wdata_o ),
      .clus_rsp_i   ( clus_rsp_i   ),
      .clus_rdata_i ( clus_rdata_i ),
      .clus_err_i   ( clus_err_i   )
   );

endmodule

/* tb_security_island_sva.sv */
/*
 Bound checker for security_island. Expected values come from the address
 map and the req/gnt/rsp rules; every target is assumed to answer each req.
*/

`timescale 1ns/100ps

module tb_security_island_sva (
   input logic                          clk_i,
   input logic                          rst_i,
   input logic                          fetch_en_i,
   input logic                          irq_i,
   input logic                          fetch_en_o,
   input logic                          irq_o,
   input logic                          rot_req_i,
   input logic                          rot_we_i,
   input logic [island_pkg::ADDR_W-1:0] rot_addr_i,
   input logic [island_pkg::DATA_W-1:0] rot_wdata_i,
   input logic                          rot_gnt_o,
   input logic                          rot_rsp_o,
   input logic [island_pkg::DATA_W-1:0] rot_rdata_o,
   input logic                          rot_err_o,
   input logic                          cls_req_i,
   input logic                          cls_we_i,
   input logic [island_pkg::ADDR_W-1:0] cls_addr_i,
   input logic [island_pkg::DATA_W-1:0] cls_wdata_i,
   input logic                          cls_gnt_o,
   input logic                          cls_rsp_o,
   input logic [island_pkg::DATA_W-1:0] cls_rdata_o,
   input logic                          cls_err_o,
   input logic                          soc_req_o,
   input logic                          soc_we_o,
   input logic [island_pkg::ADDR_W-1:0] soc_addr_o,
   input logic [island_pkg::DATA_W-1:0] soc_wdata_o,
   input logic                          soc_rsp_i,
   input logic [island_pkg::DATA_W-1:0] soc_rdata_i,
   input logic                          soc_err_i,
   input logic                          clus_req_o,
   input logic                          clus_we_o,
   input logic [island_pkg::ADDR_W-1:0] clus_addr_o,
   input logic [island_pkg::DATA_W-1:0] clus_wdata_o,
   input logic                          clus_rsp_i,
   input logic [island_pkg::DATA_W-1:0] clus_rdata_i,
   input logic                          clus_err_i
);

   import island_pkg::*;

   // 0 host, 1 cluster, 2 unmapped
   function automatic logic [1:0] window_of(input logic [ADDR_W-1:0] a);
      if (a >= HOST_BASE && a < HOST_END) begin
         return 2'd0;
      end
      if (a >= CLS_BASE && a < CLS_END) begin
         return 2'd1;
      end
      return 2'd2;
   endfunction

   int unsigned       err_cnt = 0;
   logic [1:0]        req;
   logic [1:0]        we;
   logic [1:0]        gnt;
   logic [1:0]        rsp;
   logic [1:0]        err;
   logic [1:0]        t_req;
   logic [1:0]        t_we;
   logic [1:0]        t_rsp;
   logic [1:0]        t_err;
   logic [ADDR_W-1:0] addr [2];
   logic [ADDR_W-1:0] t_addr [2];
   logic [DATA_W-1:0] wdata [2];
   logic [DATA_W-1:0] rdata [2];
   logic [DATA_W-1:0] t_wdata [2];
   logic [DATA_W-1:0] t_rdata [2];
   logic [1:0]        hit [2];
   logic [1:0]        busy;
   logic [1:0]        own;
   logic [1:0]        last;
   logic [1:0]        contest;
   logic [1:0]        pend;
   logic [1:0]        exp_rsp;
   logic [1:0]        exp_err;
   logic [DATA_W-1:0] exp_rdata [2];

   assign req   = {cls_req_i, rot_req_i};
   assign we    = {cls_we_i, rot_we_i};
   assign gnt   = {cls_gnt_o, rot_gnt_o};
   assign rsp   = {cls_rsp_o, rot_rsp_o};
   assign err   = {cls_err_o, rot_err_o};
   assign t_req = {clus_req_o, soc_req_o};
   assign t_we  = {clus_we_o, soc_we_o};
   assign t_rsp = {clus_rsp_i, soc_rsp_i};
   assign t_err = {clus_err_i, soc_err_i};
   assign addr    = '{rot_addr_i, cls_addr_i};
   assign wdata   = '{rot_wdata_i, cls_wdata_i};
   assign rdata   = '{rot_rdata_o, cls_rdata_o};
   assign t_addr  = '{soc_addr_o, clus_addr_o};
   assign t_wdata = '{soc_wdata_o, clus_wdata_o};
   assign t_rdata = '{soc_rdata_i, clus_rdata_i};

   // Which granted requester maps to which target this cycle
   always_comb begin
      for (int t = 0; t < 2; t++) begin
         for (int r = 0; r < 2; r++) begin
            hit[t][r] = gnt[r] && (window_of(addr[r]) == 2'(t));
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Reference model of ownership and expected responses
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         busy    <= '0;
         own     <= '0;
         last    <= 2'b11;
         contest <= '0;
         pend    <= '0;
         exp_rsp <= '0;
         exp_err <= '0;
         exp_rdata <= '{'0, '0};
      end else begin
         for (int t = 0; t < 2; t++) begin
            contest[t] <= req == 2'b11 && pend == 2'b00 && gnt == 2'b00 &&
                          window_of(addr[0]) == 2'(t) && window_of(addr[1]) == 2'(t);
            if (t_req[t]) begin
               busy[t] <= 1'b1;
               own[t]  <= hit[t][1];
               last[t] <= hit[t][1];
            end else if (t_rsp[t]) begin
               busy[t] <= 1'b0;
            end
         end
         for (int r = 0; r < 2; r++) begin
            exp_rsp[r] <= 1'b0;
            if (gnt[r]) begin
               pend[r] <= 1'b1;
            end else if (rsp[r]) begin
               pend[r] <= 1'b0;
            end
            if (gnt[r] && window_of(addr[r]) == 2'd2) begin
               exp_rsp[r]   <= 1'b1;
               exp_rdata[r] <= '0;
               exp_err[r]   <= 1'b1;
            end
            for (int t = 0; t < 2; t++) begin
               if (t_rsp[t] && own[t] == 1'(r)) begin
                  exp_rsp[r]   <= 1'b1;
                  exp_rdata[r] <= t_rdata[t];
                  exp_err[r]   <= t_err[t];
               end
            end
         end
      end
   end

   a_reset: assert property (@(posedge clk_i) rst_i |=> gnt == 2'b00 && rsp == 2'b00 &&
                             t_req == 2'b00 && !fetch_en_o && !irq_o)
      else begin
         $error("error outputs not idle after reset gnt %h rsp %h", gnt, rsp);
         err_cnt++;
      end

   a_sync: assert property (@(posedge clk_i) disable iff (rst_i)
                            {irq_o, fetch_en_o} == $past({irq_i, fetch_en_i}, 3))
      else begin
         $error("error {irq_o,fetch_en_o} %h", {irq_o, fetch_en_o});
         err_cnt++;
      end

   for (genvar r = 0; r < 2; r++) begin : g_req
      a_one_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
                                  gnt[r] |-> req[r] && !pend[r])
         else begin
            $error("error gnt %0d with req %h pend %h", r, req[r], pend[r]);
            err_cnt++;
         end
      a_miss_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
                                   $rose(req[r]) && window_of(addr[r]) == 2'd2 |=> gnt[r])
         else begin
            $error("unmapped request of requester %0d was not granted in time", r);
            err_cnt++;
         end
      a_rsp: assert property (@(posedge clk_i) disable iff (rst_i) rsp[r] == exp_rsp[r])
         else begin
            $error("error rsp %0d is %h expected %h", r, rsp[r], exp_rsp[r]);
            err_cnt++;
         end
      a_rdata: assert property (@(posedge clk_i) disable iff (rst_i)
                                rsp[r] |-> rdata[r] == exp_rdata[r] && err[r] == exp_err[r])
         else begin
            $error("error rdata %0d is %h err %h expected %h err %h", r, rdata[r],
                   err[r], exp_rdata[r], exp_err[r]);
            err_cnt++;
         end
   end

   for (genvar t = 0; t < 2; t++) begin : g_tgt
      a_route: assert property (@(posedge clk_i) disable iff (rst_i)
                                t_req[t] == (|hit[t]) && $onehot0(hit[t]))
         else begin
            $error("error target %0d req %h grants %h", t, t_req[t], hit[t]);
            err_cnt++;
         end
      a_payload: assert property (@(posedge clk_i) disable iff (rst_i)
                                  t_req[t] |-> t_addr[t] == addr[hit[t][1]] &&
                                  t_we[t] == we[hit[t][1]] && t_wdata[t] == wdata[hit[t][1]])
         else begin
            $error("error target %0d addr %h expected %h", t, t_addr[t],
                   addr[hit[t][1]]);
            err_cnt++;
         end
      a_busy: assert property (@(posedge clk_i) disable iff (rst_i) t_req[t] |-> !busy[t])
         else begin
            $error("target %0d got a second request before its response", t);
            err_cnt++;
         end
      a_rr: assert property (@(posedge clk_i) disable iff (rst_i)
                             t_req[t] && contest[t] |-> hit[t][1] != last[t])
         else begin
            $error("error target %0d winner %h last %h", t, hit[t][1], last[t]);
            err_cnt++;
         end
   end

endmodule

bind security_island tb_security_island_sva i_sva (.*);

/* tb_security_island.sv */
/*
 Testbench for security_island. Bound assertions do all checking; this
 module drives LFSR stimulus, models both targets and ends the run.
*/

`timescale 1ns/100ps

module tb_security_island;

   import island_pkg::*;

   localparam int NUM_TXN      = 60;
   // Two contended rounds and one solo request per window
   localparam int NUM_DIRECTED = 10;
   localparam int TIMEOUT_CYC  = (2 * NUM_TXN + NUM_DIRECTED) * 40 + 20;

   logic              clk_i = 1'b0;
   logic              rst_i = 1'b1;
   logic              fetch_en_i = 1'b0;
   logic              irq_i = 1'b0;
   logic              fetch_en_o;
   logic              irq_o;
   logic [1:0]        req_d = '0;
   logic [1:0]        we_d = '0;
   logic [ADDR_W-1:0] addr_d [2] = '{'0, '0};
   logic [DATA_W-1:0] wdata_d [2] = '{'0, '0};
   logic [1:0]        gnt_s;
   logic [1:0]        rsp_s;
   logic [1:0]        err_s;
   logic [DATA_W-1:0] rdata_s [2];
   logic [1:0]        t_req_s;
   logic [1:0]        t_we_s;
   logic [ADDR_W-1:0] t_addr_s [2];
   logic [DATA_W-1:0] t_wdata_s [2];
   logic [1:0]        t_rsp_d = '0;
   logic [DATA_W-1:0] t_rdata_d [2] = '{'0, '0};
   logic [1:0]        t_err_d = '0;
   logic [31:0]       lfsr = 32'h484a6496;

   always #10 clk_i = ~clk_i;

   security_island i_dut (
      .clk_i (clk_i), .rst_i (rst_i),
      .fetch_en_i (fetch_en_i), .irq_i (irq_i),
      .fetch_en_o (fetch_en_o), .irq_o (irq_o),
      .rot_req_i (req_d[0]), .rot_we_i (we_d[0]),
      .rot_addr_i (addr_d[0]), .rot_wdata_i (wdata_d[0]),
      .rot_gnt_o (gnt_s[0]), .rot_rsp_o (rsp_s[0]),
      .rot_rdata_o (rdata_s[0]), .rot_err_o (err_s[0]),
      .cls_req_i (req_d[1]), .cls_we_i (we_d[1]),
      .cls_addr_i (addr_d[1]), .cls_wdata_i (wdata_d[1]),
      .cls_gnt_o (gnt_s[1]), .cls_rsp_o (rsp_s[1]),
      .cls_rdata_o (rdata_s[1]), .cls_err_o (err_s[1]),
      .soc_req_o (t_req_s[0]), .soc_we_o (t_we_s[0]),
      .soc_addr_o (t_addr_s[0]), .soc_wdata_o (t_wdata_s[0]),
      .soc_rsp_i (t_rsp_d[0]), .soc_rdata_i (t_rdata_d[0]), .soc_err_i (t_err_d[0]),
      .clus_req_o (t_req_s[1]), .clus_we_o (t_we_s[1]),
      .clus_addr_o (t_addr_s[1]), .clus_wdata_o (t_wdata_s[1]),
      .clus_rsp_i (t_rsp_d[1]), .clus_rdata_i (t_rdata_d[1]), .clus_err_i (t_err_d[1])
   );

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   // Window interiors, both sides of every window edge, and unmapped space
   function automatic logic [ADDR_W-1:0] pick_addr();
      case (take_bits(3))
         32'd0:   return HOST_BASE + take_bits(28);
         32'd1:   return CLS_BASE + take_bits(24);
         32'd2:   return HOST_BASE - take_bits(1);
         32'd3:   return HOST_END - take_bits(1);
         32'd4:   return CLS_BASE - take_bits(1);
         32'd5:   return CLS_END - take_bits(1);
         32'd6:   return take_bits(16);
         default: return CLS_END + take_bits(28);
      endcase
   endfunction

   // One full transaction, then idle at least one cycle after the response
   task automatic issue_txn(input int r, input logic [ADDR_W-1:0] a);
      addr_d[r]  = a;
      wdata_d[r] = take_bits(32);
      we_d[r]    = take_bits(1) != 0;
      req_d[r]   = 1'b1;
      do begin
         @(posedge clk_i);
         #1;
      end while (!gnt_s[r]);
      @(posedge clk_i);
      #1;
      req_d[r] = 1'b0;
      while (!rsp_s[r]) begin
         @(posedge clk_i);
         #1;
      end
      @(posedge clk_i);
      #1;
   endtask

   // Both requesters ask for the same window in the same cycle
   task automatic contend(input logic [ADDR_W-1:0] base);
      logic [ADDR_W-1:0] a0;
      logic [ADDR_W-1:0] a1;
      a0 = base + take_bits(12);
      a1 = base + take_bits(12);
      fork
         issue_txn(0, a0);
         issue_txn(1, a1);
      join
   endtask

   task automatic run_requester(input int r);
      for (int n = 0; n < NUM_TXN; n++) begin
         issue_txn(r, pick_addr());
         repeat (take_bits(2)) begin
            @(posedge clk_i);
            #1;
         end
      end
   endtask

   // Answers 0 to 3 cycles after the first possible response cycle
   task automatic serve_target(input int t);
      logic [ADDR_W-1:0] a;
      forever begin
         @(posedge clk_i);
         #1;
         if (t_req_s[t]) begin
            a = t_addr_s[t];
            repeat (take_bits(2) + 1) begin
               @(posedge clk_i);
               #1;
            end
            t_rsp_d[t]   = 1'b1;
            t_rdata_d[t] = a ^ ((t == 0) ? 32'h5A5A_0F0F : 32'hC3C3_3C3C);
            @(posedge clk_i);
            #1;
            t_rsp_d[t] = 1'b0;
         end
      end
   endtask

   initial serve_target(0);
   initial serve_target(1);

   initial begin
      forever begin
         @(posedge clk_i);
         #1;
         if (!rst_i) begin
            fetch_en_i = take_bits(1) != 0;
            irq_i      = take_bits(1) != 0;
         end
      end
   end

   initial begin
      forever begin
         @(negedge clk_i);
         if (i_dut.i_sva.err_cnt != 0) begin
            $display("tests failed");
            $fatal(1, "assertion failure in bound checker");
         end
      end
   end

   initial begin
      #(TIMEOUT_CYC * 20);
      $display("tests failed");
      $fatal(1, "watchdog timeout, transactions did not complete");
   end

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      repeat (4) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      // Same-cycle contests, with rot granted alone in between
      contend(HOST_BASE);
      issue_txn(0, HOST_BASE + take_bits(12));
      contend(HOST_BASE);
      contend(CLS_BASE);
      issue_txn(0, CLS_BASE + take_bits(12));
      contend(CLS_BASE);
      fork
         run_requester(0);
         run_requester(1);
      join
      repeat (8) @(posedge clk_i);
      if (i_dut.i_sva.err_cnt == 0) begin
         $display("all tests passed");
         $finish;
      end else begin
         $display("tests failed");
         $fatal(1, "assertion failure in bound checker");
      end
   end

endmodule

/* security_island.f */
island_pkg.sv
island_bus_if.sv
island_sync.sv
island_tgt_arbiter.sv
island_xbar.sv
security_island.sv
tb_security_island_sva.sv
tb_security_island.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_security_island \
   -f security_island.f -o sim_security_island

if ! out=$(./obj_dir/sim_security_island); then
   echo "$out"
   exit 1
fi
echo "$out"
echo "$out" | grep -qx "all tests passed"
